//--- sources.f
verilog/cacheCfgPkg.sv
verilog/fetchPkg.sv
verilog/iCacheCntrl.sv
verilog/iCacheMem.sv
verilog/fetchAligner.sv
verilog/icache.sv
verif/tbClock.sv
verif/icacheProtocol_chk.sv
verif/icacheChecker.sv
verif/icacheTb.sv

//--- Bender.yml
package:
  name: icache

sources:
  # Packages first, then the design from leaf blocks up
  - verilog/cacheCfgPkg.sv
  - verilog/fetchPkg.sv
  - verilog/iCacheCntrl.sv
  - verilog/iCacheMem.sv
  - verilog/fetchAligner.sv
  - verilog/icache.sv

  - target: test
    files:
      - verif/tbClock.sv
      - verif/icacheProtocol_chk.sv
      - verif/icacheChecker.sv
      - verif/icacheTb.sv

//--- verif/icacheTb.sv
////////////////////////////////////////
// Instruction cache testbench
// Stimulus table, bus memory, hazard model,
// watchdog and the final verdict
////////////////////////////////////////

`timescale 1ns/1ps

module icacheTb;

  typedef struct {
    logic [8*16-1:0] name;
    logic [31:0]     pc;
    logic            expMiss;
    logic            flush;
    logic            stall;
  } testEntry_t;

  logic clk;
  logic reset;
  logic [31:0] PCNextF;
  logic [31:0] PCPF;
  logic StallF;
  logic StallD;
  logic FlushD;
  logic [31:0] InstrPAdrF;
  logic InstrReadF;
  logic [31:0] InstrInF;
  logic InstrAckF;
  logic CompressedF;
  logic ICacheStallF;
  fetchPkg::rawInstr_t InstrRawD;

  testEntry_t tests[$];
  int curIdx;
  int nextIdx;
  int waitLeft;
  logic stallOvr;
  logic curValid;
  logic curMiss;
  logic [8*16-1:0] curName;
  logic tableReady;
  int errorCount;
  int checkCount;

  tbClock clkGen (.clk(clk), .reset(reset));

  icache dut (.*);

  bind icache icacheProtocol_chk protocolChk (.*);

  icacheChecker resultChk (
    .clk(clk), .reset(reset), .active(curValid), .testName(curName),
    .expMiss(curMiss), .flushOvr(FlushD), .stallOvr(stallOvr), .PCPF(PCPF),
    .ICacheStallF(ICacheStallF), .InstrReadF(InstrReadF), .InstrAckF(InstrAckF),
    .InstrPAdrF(InstrPAdrF), .CompressedF(CompressedF), .InstrRawD(InstrRawD),
    .errorCount(errorCount), .checkCount(checkCount)
  );

  // Pipeline hazards follow the cache stall, decode may be held on top
  assign StallF = ICacheStallF;
  assign StallD = ICacheStallF | stallOvr;

  task automatic addTest(input logic [8*16-1:0] name, input logic [31:0] pc,
                         input logic miss, input logic flush, input logic stall);
    testEntry_t e;
    e = '{name, pc, miss, flush, stall};
    tests.push_back(e);
  endtask

  // Bus memory word built from halfwords 2w+1 and 2w
  function automatic logic [31:0] memWord(input logic [31:0] adr);
    logic [31:0] w;
    logic [31:0] hiProd;
    logic [31:0] loProd;
    w = adr >> 2;
    hiProd = (2 * w + 1) * 32'h9E37 + 32'h1234;
    loProd = (2 * w) * 32'h9E37 + 32'h1234;
    return {hiProd[15:0], loProd[15:0]};
  endfunction

  // Bus memory model with a random acknowledge delay of 0 to 3 cycles
  initial begin
    void'($urandom(83287));
    forever begin
      @(negedge clk);
      InstrAckF = 1'b0;
      if (reset) begin
        waitLeft = -1;
      end else if (InstrReadF) begin
        if (waitLeft < 0) begin
          waitLeft = $urandom_range(3, 0);
        end
        if (waitLeft == 0) begin
          InstrAckF = 1'b1;
          InstrInF  = memWord(InstrPAdrF);
          waitLeft  = -1;
        end else begin
          waitLeft--;
        end
      end
    end
  end

  // Watchdog sized from the table length
  initial begin
    wait (tableReady);
    repeat (tests.size() * 40 + 10) @(posedge clk);
    $display("Watchdog expired, the fetch sequence did not finish in time");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    logic moved;
    tableReady = 1'b0;
    addTest("coldMiss", 32'h0000_0104, 1, 0, 0);
    addTest("hitOff0", 32'h0000_0100, 0, 0, 0);
    addTest("hitOff2", 32'h0000_0102, 0, 0, 0);
    addTest("hitOff6", 32'h0000_0106, 0, 0, 0);
    addTest("hitOff8", 32'h0000_0108, 0, 0, 0);
    addTest("hitOffA", 32'h0000_010A, 0, 0, 0);
    addTest("hitOffC", 32'h0000_010C, 0, 0, 0);
    addTest("lineEnd", 32'h0000_010E, 0, 0, 0);
    addTest("evictA", 32'h0000_0250, 1, 0, 0);
    addTest("evictB", 32'h0000_0350, 1, 0, 0);
    addTest("evictA2", 32'h0000_0254, 1, 0, 0);
    addTest("evictB2", 32'h0000_0352, 1, 0, 0);
    addTest("stallD", 32'h0000_0356, 0, 0, 1);
    addTest("flushD", 32'h0000_0358, 0, 1, 0);
    addTest("afterFlush", 32'h0000_035A, 0, 0, 0);
    addTest("coldLineEnd", 32'h0000_047E, 1, 0, 0);
    tableReady = 1'b1;

    // Dummy address in F until the first unstalled edge after reset
    PCPF = '0;
    PCNextF = tests[0].pc;
    FlushD = 1'b0;
    stallOvr = 1'b0;
    curValid = 1'b0;
    curMiss = 1'b0;
    curName = '0;
    InstrInF = '0;
    InstrAckF = 1'b0;
    curIdx = -1;
    nextIdx = 0;
    @(negedge reset);

    while (curIdx < tests.size()) begin
      @(posedge clk);
      moved = !ICacheStallF;
      @(negedge clk);
      if (moved) begin
        // PCPF takes the address that was read at the unstalled edge
        PCPF = PCNextF;
        curIdx = nextIdx;
        nextIdx++;
        PCNextF = (nextIdx < tests.size()) ? tests[nextIdx].pc : 32'h0;
        curValid = (curIdx < tests.size());
        if (curValid) begin
          curName  = tests[curIdx].name;
          curMiss  = tests[curIdx].expMiss;
          FlushD   = tests[curIdx].flush;
          stallOvr = tests[curIdx].stall;
        end else begin
          FlushD   = 1'b0;
          stallOvr = 1'b0;
        end
      end
    end

    // Let the checker see the last decode register load
    repeat (2) @(posedge clk);
    @(negedge clk);
    $display("checks %0d, errors %0d, assertion failures %0d",
             checkCount, errorCount, dut.protocolChk.failCount);
    if (errorCount == 0 && dut.protocolChk.failCount == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- verif/icacheChecker.sv
////////////////////////////////////////
// Result checker for the cache testbench
// Derives windows from the halfword rule,
// checks bus beats and the decode register
////////////////////////////////////////

`timescale 1ns/1ps

module icacheChecker (
  input  logic           clk,
  input  logic           reset,
  // Current table entry, active only while PCPF belongs to one
  input  logic           active,
  input  logic [8*16-1:0] testName,
  input  logic           expMiss,
  input  logic           flushOvr,
  input  logic           stallOvr,
  input  logic [31:0]    PCPF,
  // Watched DUT outputs
  input  logic           ICacheStallF,
  input  logic           InstrReadF,
  input  logic           InstrAckF,
  input  logic [31:0]    InstrPAdrF,
  input  logic           CompressedF,
  input  logic [31:0]    InstrRawD,
  output int             errorCount,
  output int             checkCount
);

  int               beats;
  logic             readSeen;
  logic             pending;
  logic [31:0]      expRaw;
  logic [31:0]      window;
  logic [31:0]      expAdr;
  logic             expComp;
  logic [8*16-1:0]  doneName;

  // Halfword h of memory is h * 0x9E37 + 0x1234, kept to 16 bits
  function automatic logic [15:0] ruleHalf(input logic [31:0] h);
    logic [31:0] prod;
    prod = h * 32'h9E37 + 32'h1234;
    return prod[15:0];
  endfunction

  // Window at a halfword address, with zeros on top at a line end
  function automatic logic [31:0] windowFor(input logic [31:0] pc);
    logic [15:0] lo;
    logic [15:0] hi;
    lo = ruleHalf(pc >> 1);
    hi = (pc[3:1] == 3'd7) ? 16'h0000 : ruleHalf((pc >> 1) + 1);
    return {hi, lo};
  endfunction

  always @(posedge clk) begin
    if (reset) begin
      beats      = 0;
      readSeen   = 1'b0;
      pending    = 1'b0;
      expRaw     = '0;
      errorCount = 0;
      checkCount = 0;
    end else begin
      // The decode register was loaded at the previous edge
      if (pending) begin
        checkCount++;
        if (InstrRawD !== expRaw) begin
          errorCount++;
          $display("[FAIL] %0s: InstrRawD expected %h, actual %h", doneName, expRaw, InstrRawD);
        end
        pending = 1'b0;
      end
      if (active) begin
        if (InstrReadF) begin
          readSeen = 1'b1;
        end
        // Beats must walk the line from its base
        if (InstrReadF && InstrAckF) begin
          expAdr = {PCPF[31:4], 4'h0} + 32'(beats * 4);
          checkCount++;
          if (InstrPAdrF !== expAdr) begin
            errorCount++;
            $display("[FAIL] %0s: bus address expected %h, actual %h", testName,
                     expAdr, InstrPAdrF);
          end
          beats++;
        end
        // Fetch of PCPF completes in this cycle
        if (!ICacheStallF) begin
          window  = windowFor(PCPF);
          expComp = (window[1:0] != 2'b11);
          checkCount += 2;
          if (CompressedF !== expComp) begin
            errorCount++;
            $display("[FAIL] %0s: CompressedF expected %b, actual %b", testName,
                     expComp, CompressedF);
          end
          if (beats != (expMiss ? 4 : 0)) begin
            errorCount++;
            $display("[FAIL] %0s: bus beats expected %0d, actual %0d", testName,
                     expMiss ? 4 : 0, beats);
          end
          if (!expMiss && readSeen) begin
            errorCount++;
            $display("%0s: a hit raised a bus read", testName);
          end
          if (flushOvr) begin
            expRaw = '0;
          end else if (!stallOvr) begin
            expRaw = window;
          end
          pending  = 1'b1;
          doneName = testName;
          beats    = 0;
          readSeen = 1'b0;
        end
      end
    end
  end

endmodule

//--- verif/icacheProtocol_chk.sv
////////////////////////////////////////
// Refill bus protocol assertions
// Bound into the cache top level
////////////////////////////////////////

`timescale 1ns/1ps

module icacheProtocol_chk (
  input logic        clk,
  input logic        reset,
  input logic        InstrReadF,
  input logic        InstrAckF,
  input logic        ICacheStallF,
  input logic [31:0] InstrPAdrF
);

  // Number of assertion failures, read by the testbench at the end
  int failCount = 0;

  // A request without an acknowledge keeps its address
  addrStable: assert property (@(posedge clk) disable iff (reset)
    (InstrReadF && !InstrAckF) |=> $stable(InstrPAdrF))
    else begin
      failCount++;
      $error("bus address changed while a read was waiting for its acknowledge");
    end

  // The pipeline must be held while the bus is busy
  readStalls: assert property (@(posedge clk) disable iff (reset)
    InstrReadF |-> ICacheStallF)
    else begin
      failCount++;
      $error("bus read active without a fetch stall");
    end

  quietAfterReset: assert property (@(posedge clk) $fell(reset) |-> !InstrReadF)
    else begin
      failCount++;
      $error("bus read active in the first cycle after reset");
    end

endmodule

//--- verif/tbClock.sv
////////////////////////////////////////
// Testbench clock and reset
// 4 ns clock, reset held for 4 cycles
////////////////////////////////////////

`timescale 1ns/1ps

module tbClock (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Reset drops on a falling edge after four rising edges
  initial begin
    reset = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

//--- verilog/icache.sv
////////////////////////////////////////
// Instruction cache top level
// Refill controller, arrays and fetch
// aligner between the fetch stage and the bus
////////////////////////////////////////

`timescale 1ns/1ps

module icache (
  input  logic                         clk,
  input  logic                         reset,
  // Pipeline control and fetch addresses
  input  logic [cacheCfgPkg::XLEN-1:0] PCNextF,
  input  logic [cacheCfgPkg::XLEN-1:0] PCPF,
  input  logic                         StallF,
  input  logic                         StallD,
  input  logic                         FlushD,
  // Bus request
  output logic [cacheCfgPkg::XLEN-1:0] InstrPAdrF,
  output logic                         InstrReadF,
  // Bus return
  input  logic [cacheCfgPkg::XLEN-1:0] InstrInF,
  input  logic                         InstrAckF,
  // Results for the pipeline
  output logic                         CompressedF,
  output logic                         ICacheStallF,
  output fetchPkg::rawInstr_t          InstrRawD
);

  // Line read for the current fetch address and its hit flag
  logic [cacheCfgPkg::LINE_BITS-1:0] ReadLineF;
  logic                              HitF;

  // Refilled line on its way into the arrays
  logic                              LineWriteEn;
  logic [cacheCfgPkg::LINE_BITS-1:0] LineWriteData;

  // Producer of lines
  iCacheCntrl cntrl (
    .clk          (clk),
    .reset        (reset),
    .PCPF         (PCPF),
    .HitF         (HitF),
    .InstrInF     (InstrInF),
    .InstrAckF    (InstrAckF),
    .InstrPAdrF   (InstrPAdrF),
    .InstrReadF   (InstrReadF),
    .ICacheStallF (ICacheStallF),
    .LineWriteEn  (LineWriteEn),
    .LineWriteData(LineWriteData)
  );

  // Line storage
  iCacheMem mem (
    .clk          (clk),
    .reset        (reset),
    .StallF       (StallF),
    .PCNextF      (PCNextF),
    .PCPF         (PCPF),
    .LineWriteEn  (LineWriteEn),
    .LineWriteData(LineWriteData),
    .ReadLineF    (ReadLineF),
    .HitF         (HitF)
  );

  // Consumer that feeds decode
  fetchAligner aligner (
    .clk        (clk),
    .reset      (reset),
    .PCPF       (PCPF),
    .ReadLineF  (ReadLineF),
    .StallD     (StallD),
    .FlushD     (FlushD),
    .CompressedF(CompressedF),
    .InstrRawD  (InstrRawD)
  );

endmodule

//--- verilog/fetchAligner.sv
////////////////////////////////////////
// Fetch window aligner
// Picks the 32-bit window at the halfword
// offset of the fetch address, flags compressed
// instructions and holds the decode register
////////////////////////////////////////

`timescale 1ns/1ps

module fetchAligner (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [cacheCfgPkg::XLEN-1:0]      PCPF,
  input  logic [cacheCfgPkg::LINE_BITS-1:0] ReadLineF,
  input  logic                              StallD,
  input  logic                              FlushD,
  output logic                              CompressedF,
  output fetchPkg::rawInstr_t               InstrRawD
);

  // The line viewed as halfwords, lowest address at index 0
  logic [cacheCfgPkg::HALVES_PER_LINE-1:0][15:0] lineHalves;

  // Halfword offset inside the line and the one after it
  logic [cacheCfgPkg::OFFSET_BITS-2:0] halfOffset;
  logic [cacheCfgPkg::OFFSET_BITS-2:0] nextOffset;
  logic                                lastHalf;

  fetchPkg::rawInstr_t windowF;

  ////////////////////////////////////////
  // Window select
  ////////////////////////////////////////

  assign lineHalves = ReadLineF;
  assign halfOffset = PCPF[cacheCfgPkg::OFFSET_BITS-1:1];
  assign nextOffset = halfOffset + 1'b1;

  // The window does not cross into the next line
  assign lastHalf = (halfOffset ==
    (cacheCfgPkg::OFFSET_BITS-1)'(cacheCfgPkg::HALVES_PER_LINE - 1));

  always_comb begin
    windowF.halves[0] = lineHalves[halfOffset];
    // Last halfword of a line gets zeros on top
    windowF.halves[1] = lastHalf ? 16'h0000 : lineHalves[nextOffset];
  end

  // Anything outside quadrant 3 is a 16-bit instruction
  assign CompressedF = (windowF.halves[0][1:0] != fetchPkg::UNCOMPRESSED_OP);

  ////////////////////////////////////////
  // Decode stage register
  ////////////////////////////////////////

  // Flush wins over stall, a flushed slot decodes as all zeros
  always_ff @(posedge clk) begin
    if (reset || FlushD) begin
      InstrRawD.word <= '0;
    end else if (!StallD) begin
      InstrRawD.word <= windowF.word;
    end
  end

endmodule

//--- verilog/iCacheMem.sv
////////////////////////////////////////
// Instruction cache arrays
// Direct-mapped tag, valid and data storage
// with a registered read and the hit compare
////////////////////////////////////////

`timescale 1ns/1ps

module iCacheMem (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              StallF,
  input  logic [cacheCfgPkg::XLEN-1:0]      PCNextF,
  input  logic [cacheCfgPkg::XLEN-1:0]      PCPF,
  input  logic                              LineWriteEn,
  input  logic [cacheCfgPkg::LINE_BITS-1:0] LineWriteData,
  output logic [cacheCfgPkg::LINE_BITS-1:0] ReadLineF,
  output logic                              HitF
);

  logic [cacheCfgPkg::LINE_BITS-1:0] dataArr [cacheCfgPkg::NUM_LINES];
  logic [cacheCfgPkg::TAG_BITS-1:0]  tagArr  [cacheCfgPkg::NUM_LINES];
  logic [cacheCfgPkg::NUM_LINES-1:0] validVec;

  logic [cacheCfgPkg::INDEX_BITS-1:0] readIndex;
  logic [cacheCfgPkg::INDEX_BITS-1:0] writeIndex;
  logic [cacheCfgPkg::TAG_BITS-1:0]   pcTag;
  logic                               writeBypass;

  // Registered read results
  logic [cacheCfgPkg::TAG_BITS-1:0] readTag;
  logic                             readValid;

  ////////////////////////////////////////
  // Index and tag fields
  ////////////////////////////////////////

  // A stalled cycle rereads the current fetch line instead of the next one
  assign readIndex = StallF ?
    PCPF[cacheCfgPkg::OFFSET_BITS +: cacheCfgPkg::INDEX_BITS] :
    PCNextF[cacheCfgPkg::OFFSET_BITS +: cacheCfgPkg::INDEX_BITS];
  assign writeIndex = PCPF[cacheCfgPkg::OFFSET_BITS +: cacheCfgPkg::INDEX_BITS];
  assign pcTag = PCPF[cacheCfgPkg::XLEN-1 -: cacheCfgPkg::TAG_BITS];

  // Read and write to the same line at one edge return the new line
  assign writeBypass = LineWriteEn & (readIndex == writeIndex);

  // Valid bits are cleared so every line misses once after reset
  always_ff @(posedge clk) begin
    if (reset) begin
      validVec  <= '0;
      readValid <= 1'b0;
    end else begin
      if (LineWriteEn) begin
        validVec[writeIndex] <= 1'b1;
      end
      readValid <= writeBypass | validVec[readIndex];
    end
  end

  // Storage and read data
  always_ff @(posedge clk) begin
    if (LineWriteEn) begin
      dataArr[writeIndex] <= LineWriteData;
      tagArr[writeIndex]  <= pcTag;
    end
    ReadLineF <= writeBypass ? LineWriteData : dataArr[readIndex];
    readTag   <= writeBypass ? pcTag : tagArr[readIndex];
  end

  // Compare against the address that is now in F
  assign HitF = readValid & (readTag == pcTag);

endmodule

//--- verilog/iCacheCntrl.sv
////////////////////////////////////////
// Instruction cache refill controller
// Detects a miss on the fetch address, reads
// the missing line word by word from the bus,
// assembles it and writes it to the arrays
////////////////////////////////////////

`timescale 1ns/1ps

module iCacheCntrl (
  input  logic                              clk,
  input  logic                              reset,
  // Physical fetch address of the F stage
  input  logic [cacheCfgPkg::XLEN-1:0]      PCPF,
  input  logic                              HitF,
  // Bus return path
  input  logic [cacheCfgPkg::XLEN-1:0]      InstrInF,
  input  logic                              InstrAckF,
  // Bus request path
  output logic [cacheCfgPkg::XLEN-1:0]      InstrPAdrF,
  output logic                              InstrReadF,
  output logic                              ICacheStallF,
  // Line write port into the arrays
  output logic                              LineWriteEn,
  output logic [cacheCfgPkg::LINE_BITS-1:0] LineWriteData
);

  // Tag and index of the line being refilled
  logic [cacheCfgPkg::XLEN-cacheCfgPkg::OFFSET_BITS-1:0] lineBase;
  // Word position inside the line, also the bus address bits above the byte lane
  logic [cacheCfgPkg::OFFSET_BITS-3:0] beatCount;
  logic [cacheCfgPkg::LINE_BITS-1:0]   lineBuf;

  // The state machine is kept as two flags
  // Both low is idle, fetching runs the bus, writing is the single write cycle
  logic fetching;
  logic writing;

  // Low through reset and for the first cycle after it,
  // so no miss is taken on the address the pipeline is still loading
  logic armed;

  logic startRefill;
  logic lastBeat;
  logic beatAccepted;

  ////////////////////////////////////////
  // Miss detection
  ////////////////////////////////////////

  // A miss starts a refill only from idle
  assign startRefill = armed & ~fetching & ~writing & ~HitF;

  // Any cycle without a hit stalls fetch, as does a refill in flight
  assign ICacheStallF = armed & (~HitF | fetching | writing);

  assign beatAccepted = fetching & InstrAckF;
  assign lastBeat = (beatCount ==
    (cacheCfgPkg::OFFSET_BITS-2)'(cacheCfgPkg::BEATS_PER_LINE - 1));

  ////////////////////////////////////////
  // Refill state machine
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      armed     <= 1'b0;
      fetching  <= 1'b0;
      writing   <= 1'b0;
      beatCount <= '0;
    end else begin
      armed <= 1'b1;
      // Writing lasts exactly one cycle
      writing <= 1'b0;
      if (startRefill) begin
        fetching  <= 1'b1;
        beatCount <= '0;
      end else if (beatAccepted) begin
        beatCount <= beatCount + 1'b1;
        // The request drops in the cycle after the fourth acknowledge
        if (lastBeat) begin
          fetching <= 1'b0;
          writing  <= 1'b1;
        end
      end
    end
  end

  // Line base is latched at the miss, PCPF is stalled but this keeps the bus address
  // independent of the pipeline
  always_ff @(posedge clk) begin
    if (startRefill) begin
      lineBase <= PCPF[cacheCfgPkg::XLEN-1:cacheCfgPkg::OFFSET_BITS];
    end
  end

  // Each acknowledged word lands in its own slot of the line
  always_ff @(posedge clk) begin
    if (beatAccepted) begin
      lineBuf[beatCount*cacheCfgPkg::XLEN +: cacheCfgPkg::XLEN] <= InstrInF;
    end
  end

  ////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////

  // Address stays fixed until the acknowledge advances the beat
  assign InstrPAdrF = {lineBase, beatCount, 2'b00};
  assign InstrReadF = fetching;

  assign LineWriteEn   = writing;
  assign LineWriteData = lineBuf;

endmodule

//--- verilog/fetchPkg.sv
////////////////////////////////////////
// Instruction encoding definitions
// The raw fetch word and the opcode quadrant
// that marks a full-length instruction
////////////////////////////////////////

package fetchPkg;

  // A raw instruction window is read as one word by decode,
  // but it is assembled from two halfwords by the aligner
  typedef union packed {
    // Whole 32-bit instruction word
    logic [31:0]      word;
    // Index 1 is the upper halfword, index 0 the lower one
    logic [1:0][15:0] halves;
  } rawInstr_t;

  ////////////////////////////////////////
  // Compressed extension
  ////////////////////////////////////////

  // Quadrants 0 to 2 of the two low opcode bits hold
  // 16-bit compressed instructions
  // Quadrant 3 means the instruction is 32 bits long
  localparam logic [1:0] UNCOMPRESSED_OP = 2'b11;

  // The window must hold at least one full-length instruction
  localparam int WINDOW_BITS = $bits(rawInstr_t);

endpackage

//--- verilog/cacheCfgPkg.sv
////////////////////////////////////////
// Instruction cache geometry
// Word width, line size and the split of a
// physical fetch address into tag, index and
// byte offset for the direct-mapped cache
////////////////////////////////////////

package cacheCfgPkg;

  // Address width and bus word width
  localparam int XLEN = 32;

  // One line is four bus words
  localparam int LINE_BITS = 128;
  localparam int NUM_LINES = 16;
  localparam int BEATS_PER_LINE = LINE_BITS / XLEN;

  ////////////////////////////////////////
  // Address fields
  ////////////////////////////////////////

  // Byte offset inside a line, the low bits of the address
  localparam int OFFSET_BITS = 4;
  // Line index, directly above the offset
  localparam int INDEX_BITS = 4;
  // Everything above the index is tag
  localparam int TAG_BITS = XLEN - INDEX_BITS - OFFSET_BITS;

  // Fetch windows start on any halfword of a line
  localparam int HALVES_PER_LINE = LINE_BITS / 16;

endpackage
